// File: list.f
source/starfield_pkg.sv
source/display_timings.sv
source/starfield.sv
source/star_mixer.sv
source/starfield_top.sv
tests/starfield_tb.sv

// File: source/display_timings.sv
/* Display timing generator: pixel position counters plus sync and data enable.
   Porch and sync sizes are parameters, so simulation can run a tiny frame. */

`timescale 1ns/100ps

module display_timings #(
    parameter logic [starfield_pkg::CORDW-1:0] H_RES  = 640,  // Active pixels per line
    parameter logic [starfield_pkg::CORDW-1:0] V_RES  = 480,  // Active lines per frame
    parameter logic [starfield_pkg::CORDW-1:0] H_FP   = 16,   // Horizontal front porch
    parameter logic [starfield_pkg::CORDW-1:0] H_SYNC = 96,   // Horizontal sync width
    parameter logic [starfield_pkg::CORDW-1:0] H_BP   = 48,   // Horizontal back porch
    parameter logic [starfield_pkg::CORDW-1:0] V_FP   = 10,   // Vertical front porch
    parameter logic [starfield_pkg::CORDW-1:0] V_SYNC = 2,    // Vertical sync lines
    parameter logic [starfield_pkg::CORDW-1:0] V_BP   = 33    // Vertical back porch
) (
    input  logic                            clk_pix,  // Pixel clock
    input  logic                            reset,    // Sync reset, active high
    output logic [starfield_pkg::CORDW-1:0] sx,       // Horizontal position
    output logic [starfield_pkg::CORDW-1:0] sy,       // Vertical position
    output logic                            hsync,    // Active low
    output logic                            vsync,    // Active low
    output logic                            de        // High in active area
);
    import starfield_pkg::*;

    // Sync spans start right after the front porch
    localparam logic [CORDW-1:0] H_SYNC_STA = H_RES + H_FP;
    localparam logic [CORDW-1:0] H_SYNC_END = H_SYNC_STA + H_SYNC;  // First pixel after sync
    localparam logic [CORDW-1:0] H_TOTAL    = H_SYNC_END + H_BP;
    localparam logic [CORDW-1:0] V_SYNC_STA = V_RES + V_FP;
    localparam logic [CORDW-1:0] V_SYNC_END = V_SYNC_STA + V_SYNC;
    localparam logic [CORDW-1:0] V_TOTAL    = V_SYNC_END + V_BP;

    logic line_end;   // Last pixel of a line
    logic frame_end;  // Last line of a frame

    assign line_end  = (sx == H_TOTAL - 1'b1);
    assign frame_end = (sy == V_TOTAL - 1'b1);

    // Scan left to right, then top to bottom
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            sx <= '0;
            sy <= '0;
        end else if (line_end) begin
            sx <= '0;
            sy <= frame_end ? '0 : sy + 1'b1;  // Wrap at frame end
        end else begin
            sx <= sx + 1'b1;
        end
    end

    // Decode straight from the counters, no added latency
    always_comb begin
        hsync = ~((sx >= H_SYNC_STA) && (sx < H_SYNC_END));
        vsync = ~((sy >= V_SYNC_STA) && (sy < V_SYNC_END));
        de    = (sx < H_RES) && (sy < V_RES);
    end

    // Horizontal counter must wrap before the line total
    a_sx_in_range : assert property (
        @(posedge clk_pix) disable iff (reset)
        sx < H_TOTAL
    ) else $error("sx %0d reached line total %0d", sx, H_TOTAL);

endmodule

// File: source/star_mixer.sv
/* Combines three star layers into one 12-bit video pixel.
   Applies layer priority and blanking, then registers syncs, enable and colour. */

`timescale 1ns/100ps

module star_mixer (
    input  logic                             clk_pix,    // Pixel clock
    input  logic                             reset,      // Sync reset, active high
    input  logic                             sf1_on,     // Layer 1 lit
    input  logic                             sf2_on,     // Layer 2 lit
    input  logic                             sf3_on,     // Layer 3 lit
    input  logic [starfield_pkg::STAR_W-1:0] sf1_star,
    input  logic [starfield_pkg::STAR_W-1:0] sf2_star,
    input  logic [starfield_pkg::STAR_W-1:0] sf3_star,
    input  logic                             hsync,      // From timing, active low
    input  logic                             vsync,      // From timing, active low
    input  logic                             de,         // From timing
    output logic                             hsync_out,
    output logic                             vsync_out,
    output logic                             de_out,
    output logic [starfield_pkg::COLR_W-1:0] red,
    output logic [starfield_pkg::COLR_W-1:0] green,
    output logic [starfield_pkg::COLR_W-1:0] blue
);
    import starfield_pkg::*;

    logic [COLR_W-1:0] starlight;  // Selected brightness
    logic [COLR_W-1:0] pix;        // After blanking

    // Layer 1 wins, then 2, then 3
    always_comb begin
        if (sf1_on)      starlight = sf1_star[STAR_W-1 -: COLR_W];
        else if (sf2_on) starlight = sf2_star[STAR_W-1 -: COLR_W];
        else if (sf3_on) starlight = sf3_star[STAR_W-1 -: COLR_W];
        else             starlight = '0;  // Empty sky
    end

    assign pix = de ? starlight : '0;  // Black outside active area

    // Output register stage, all video signals aligned
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            hsync_out <= 1'b1;  // Sync inactive
            vsync_out <= 1'b1;
            de_out    <= 1'b0;
            red       <= '0;
            green     <= '0;
            blue      <= '0;
        end else begin
            hsync_out <= hsync;
            vsync_out <= vsync;
            de_out    <= de;
            red       <= pix;  // Greyscale stars
            green     <= pix;
            blue      <= pix;
        end
    end

    // No colour may leak into blanking
    a_blank_black : assert property (
        @(posedge clk_pix) disable iff (reset)
        !de_out |-> (red == '0) && (green == '0) && (blue == '0)
    ) else $error("Colour present while de_out low");

endmodule

// File: source/starfield.sv
/* One scrolling star layer driven by a 21-bit Galois shift register.
   The sequence restarts a few steps short of a frame, so stars drift left
   by |INC| pixels every frame. */

`timescale 1ns/100ps

module starfield #(
    parameter int                             INC       = -1,         // Drift per frame
    parameter logic [starfield_pkg::SF_W-1:0] SEED      = 21'h1FFFFF, // Restart value
    parameter logic [starfield_pkg::SF_W-1:0] MASK      = 21'h07FF,   // Star density
    parameter int                             FRAME_LEN = 800 * 525   // Clocks per frame
) (
    input  logic                             clk_pix,  // Pixel clock
    input  logic                             reset,    // Sync reset, active high
    output logic                             sf_on,    // Star lit at this pixel
    output logic [starfield_pkg::STAR_W-1:0] sf_star   // Star brightness value
);
    import starfield_pkg::*;

    // Sequence length; shorter than a frame for negative INC
    localparam int RST_CNT = FRAME_LEN + INC;
    localparam int CNT_W   = $clog2(RST_CNT);  // Holds 0 .. RST_CNT-1

    logic [CNT_W-1:0] cnt;      // Steps since last SEED load
    logic [SF_W-1:0]  sf_reg;   // Shift register state
    logic             seq_end;  // Last step of the sequence

    assign seq_end = (cnt == CNT_W'(RST_CNT - 1));

    // One step per pixel clock, reload at end of sequence
    always_ff @(posedge clk_pix) begin
        if (reset) begin
            cnt    <= '0;
            sf_reg <= SEED;
        end else if (seq_end) begin
            cnt    <= '0;
            sf_reg <= SEED;  // Restart early, shifts pattern by INC
        end else begin
            cnt    <= cnt + 1'b1;
            // Right shift, feed bit 0 back through the taps
            sf_reg <= {1'b0, sf_reg[SF_W-1:1]} ^ (sf_reg[0] ? SF_TAPS : '0);
        end
    end

    // Lit when every masked bit is set
    assign sf_on   = &(sf_reg | ~MASK);
    assign sf_star = sf_reg[SF_W-1 -: STAR_W];  // Top bits as brightness

    // All-zero state would lock the register up
    a_sf_reg_nonzero : assert property (
        @(posedge clk_pix) disable iff (reset)
        sf_reg != '0
    ) else $error("Star shift register stuck at zero");

endmodule

// File: source/starfield_pkg.sv
/* Shared widths and constants for the starfield video generator.
   Imported by the timing, starfield, mixer and top-level modules. */

package starfield_pkg;

    // Pixel coordinates and timing parameters
    localparam int CORDW = 16;  // Wide enough for any practical resolution

    // Star shift register
    localparam int SF_W = 21;  // Register, SEED and MASK width

    // Galois feedback taps 21 and 19, right-shifting form
    // Bit 20 is tap 21, bit 18 is tap 19
    localparam logic [SF_W-1:0] SF_TAPS = 21'h14_0000;

    // Star value taken from the top of the register
    localparam int STAR_W = 8;

    // One colour channel on the video output
    localparam int COLR_W = 4;  // 12-bit RGB overall

endpackage

// File: source/starfield_top.sv
/* Starfield video generator top level, running on the pixel clock.
   Display timing feeds three drifting star layers into the output mixer. */

`timescale 1ns/100ps

module starfield_top #(
    // Display timing, 640x480 by default
    parameter logic [starfield_pkg::CORDW-1:0] H_RES  = 640,
    parameter logic [starfield_pkg::CORDW-1:0] V_RES  = 480,
    parameter logic [starfield_pkg::CORDW-1:0] H_FP   = 16,
    parameter logic [starfield_pkg::CORDW-1:0] H_SYNC = 96,
    parameter logic [starfield_pkg::CORDW-1:0] H_BP   = 48,
    parameter logic [starfield_pkg::CORDW-1:0] V_FP   = 10,
    parameter logic [starfield_pkg::CORDW-1:0] V_SYNC = 2,
    parameter logic [starfield_pkg::CORDW-1:0] V_BP   = 33,
    // Star layers, nearest first
    parameter int                             INC1  = -1,
    parameter int                             INC2  = -2,
    parameter int                             INC3  = -4,          // Fastest drift
    parameter logic [starfield_pkg::SF_W-1:0] SEED1 = 21'h09A9A9,
    parameter logic [starfield_pkg::SF_W-1:0] SEED2 = 21'h0A9A9A,
    parameter logic [starfield_pkg::SF_W-1:0] SEED3 = 21'h1FFFFF,
    parameter logic [starfield_pkg::SF_W-1:0] MASK1 = 21'h000FFF,
    parameter logic [starfield_pkg::SF_W-1:0] MASK2 = 21'h000FFF,
    parameter logic [starfield_pkg::SF_W-1:0] MASK3 = 21'h0007FF   // Denser distant layer
) (
    input  logic                             clk_pix,    // Pixel clock
    input  logic                             reset,      // Sync reset, active high
    output logic                             hsync_out,  // Active low
    output logic                             vsync_out,  // Active low
    output logic                             de_out,
    output logic [starfield_pkg::COLR_W-1:0] red,
    output logic [starfield_pkg::COLR_W-1:0] green,
    output logic [starfield_pkg::COLR_W-1:0] blue
);
    import starfield_pkg::*;

    // Clocks per frame, computed 32 bits wide to avoid overflow
    localparam int H_TOTAL   = H_RES + H_FP + H_SYNC + H_BP;
    localparam int V_TOTAL   = V_RES + V_FP + V_SYNC + V_BP;
    localparam int FRAME_LEN = H_TOTAL * V_TOTAL;

    logic              hsync, vsync, de;  // Timing, unregistered
    logic              sf1_on, sf2_on, sf3_on;
    logic [STAR_W-1:0] sf1_star, sf2_star, sf3_star;

    display_timings #(
        .H_RES(H_RES), .V_RES(V_RES),
        .H_FP(H_FP), .H_SYNC(H_SYNC), .H_BP(H_BP),
        .V_FP(V_FP), .V_SYNC(V_SYNC), .V_BP(V_BP)
    ) i_display_timings (
        .clk_pix,
        .reset,
        .sx(),      // Position not needed, stars follow the clock
        .sy(),
        .hsync,
        .vsync,
        .de
    );

    // Layers run free, locked to the counters by the common reset
    starfield #(
        .INC(INC1), .SEED(SEED1), .MASK(MASK1), .FRAME_LEN(FRAME_LEN)
    ) i_sf1 (
        .clk_pix, .reset, .sf_on(sf1_on), .sf_star(sf1_star)
    );

    starfield #(
        .INC(INC2), .SEED(SEED2), .MASK(MASK2), .FRAME_LEN(FRAME_LEN)
    ) i_sf2 (
        .clk_pix, .reset, .sf_on(sf2_on), .sf_star(sf2_star)
    );

    starfield #(
        .INC(INC3), .SEED(SEED3), .MASK(MASK3), .FRAME_LEN(FRAME_LEN)
    ) i_sf3 (
        .clk_pix, .reset, .sf_on(sf3_on), .sf_star(sf3_star)
    );

    star_mixer i_star_mixer (
        .clk_pix,
        .reset,
        .sf1_on,
        .sf2_on,
        .sf3_on,
        .sf1_star,
        .sf2_star,
        .sf3_star,
        .hsync,
        .vsync,
        .de,
        .hsync_out,  // One clock behind the counters
        .vsync_out,
        .de_out,
        .red,
        .green,
        .blue
    );

endmodule

// File: tests/starfield_stim.txt
# R <cycles> = hold reset; S <cycle> <hs> <vs> <de> = sync and enable only
# P <cycle> <hs> <vs> <de> <red> <green> <blue> = full check, colours in hex
# Cycle n is sampled after the n-th rising edge since reset release
# Frame 0 reset values, then row 0 where only layer 3 is lit
P 0 1 1 0 0 0 0
P 1 1 1 1 F F F
P 2 1 1 1 D D D
P 3 1 1 1 C C C
P 4 1 1 1 C C C
P 5 1 1 1 C C C
P 6 1 1 1 C C C
P 7 1 1 1 C C C
P 8 1 1 1 C C C
P 9 1 1 1 C C C
P 10 1 1 1 0 0 0
P 11 1 1 1 0 0 0
P 12 1 1 1 0 0 0
P 13 1 1 1 0 0 0
# Line 0 active end, hsync edges, line wrap
S 32 1 1 1
P 33 1 1 0 0 0 0
P 36 1 1 0 0 0 0
P 37 0 1 0 0 0 0
P 40 0 1 0 0 0 0
P 41 1 1 0 0 0 0
P 48 1 1 0 0 0 0
S 49 1 1 1
# Last active pixel, vertical blanking and vsync lines
S 752 1 1 1
P 753 1 1 0 0 0 0
P 769 1 1 0 0 0 0
P 864 1 1 0 0 0 0
P 865 1 0 0 0 0 0
P 902 0 0 0 0 0 0
P 960 1 0 0 0 0 0
P 961 1 1 0 0 0 0
P 1056 1 1 0 0 0 0
# Frame 1, layer 3 stars moved 4 pixels left
P 1057 1 1 1 C C C
P 1058 1 1 1 C C C
P 1059 1 1 1 C C C
P 1060 1 1 1 C C C
P 1061 1 1 1 C C C
P 1062 1 1 1 0 0 0
P 1063 1 1 1 0 0 0
# Frame 2, 8 pixels left
P 2113 1 1 1 C C C
P 2114 1 1 1 0 0 0
P 2115 1 1 1 0 0 0
# Frame 3, whole lit run now off screen
P 3169 1 1 1 0 0 0
P 3170 1 1 1 0 0 0
P 3171 1 1 1 0 0 0
P 3172 1 1 1 0 0 0
# Mid-run reset, frame 0 repeats
R 10
P 0 1 1 0 0 0 0
P 1 1 1 1 F F F
P 2 1 1 1 D D D
P 3 1 1 1 C C C
P 9 1 1 1 C C C
P 10 1 1 1 0 0 0
P 13 1 1 1 0 0 0
P 37 0 1 0 0 0 0
P 41 1 1 0 0 0 0
S 752 1 1 1
P 865 1 0 0 0 0 0
P 961 1 1 0 0 0 0
P 1056 1 1 0 0 0 0

// File: tests/starfield_tb.sv
/* Testbench for the starfield video generator on a tiny 48x22 frame.
   Reads reset commands and sampled output checks from tests/starfield_stim.txt. */

`timescale 1ns/100ps

module starfield_tb;
    import starfield_pkg::*;

    // Small frame so several frames fit in a short run
    localparam int H_TOTAL      = 32 + 4 + 4 + 8;
    localparam int V_TOTAL      = 16 + 2 + 2 + 2;
    localparam int FRAME_CYCLES = H_TOTAL * V_TOTAL;    // 1056 clocks
    localparam int RESET_CYCLES = 10;
    localparam int MAX_CYCLES   = 5 * FRAME_CYCLES + 120;  // Four frames, two resets, margin

    logic              clk_pix;
    logic              reset;
    logic              hsync_out;
    logic              vsync_out;
    logic              de_out;
    logic [COLR_W-1:0] red;
    logic [COLR_W-1:0] green;
    logic [COLR_W-1:0] blue;

    int cyc;           // Rising edges since last reset release
    int total_cycles;  // All rising edges, for the timeout
    int checks;
    int mismatches;
    int other_errors;

    starfield_top #(
        .H_RES(32), .V_RES(16),
        .H_FP(4), .H_SYNC(4), .H_BP(8),
        .V_FP(2), .V_SYNC(2), .V_BP(2)
    ) i_starfield_top (
        .clk_pix,
        .reset,
        .hsync_out,
        .vsync_out,
        .de_out,
        .red,
        .green,
        .blue
    );

    // 100 ns pixel clock
    initial begin
        clk_pix = 1'b0;
        forever #50 clk_pix = ~clk_pix;
    end

    // Hard stop if the stimulus never runs out
    initial begin
        total_cycles = 0;
        while (total_cycles < MAX_CYCLES) begin
            @(posedge clk_pix);
            total_cycles++;
        end
        $display("Timeout: run reached %0d clock cycles before the stimulus file ended",
                 MAX_CYCLES);
        $display("Checks: %0d, mismatches: %0d, other errors: %0d",
                 checks, mismatches, other_errors + 1);
        $display("TESTS FAILED");
        $finish;
    end

    // Hold reset for a number of edges, inputs move 1 ns after the edge
    task automatic apply_reset(input int hold);
        @(posedge clk_pix);
        #1 reset = 1'b1;
        repeat (hold) @(posedge clk_pix);
        #1 reset = 1'b0;
        cyc = 0;  // Next edge is cycle 1
    endtask

    // Step to the given cycle, then sample mid-period
    task automatic advance_to(input int target);
        while (cyc < target) begin
            @(posedge clk_pix);
            cyc++;
        end
        @(negedge clk_pix);  // Outputs settled since the rising edge
    endtask

    task automatic compare_flag(input string name, input logic got, input logic exp);
        checks++;
        assert (got === exp) else begin
            $display("MISMATCH at %0d ns: cycle %0d, %s expected %b, got %b",
                     $time, cyc, name, exp, got);
            mismatches++;
        end
    endtask

    task automatic verify_colour(input string name, input logic [COLR_W-1:0] got,
                                 input logic [COLR_W-1:0] exp);
        checks++;
        assert (got === exp) else begin
            $display("MISMATCH at %0d ns: cycle %0d, %s expected %h, got %h",
                     $time, cyc, name, exp, got);
            mismatches++;
        end
    endtask

    // Stimulus reader, one command or check per line
    initial begin
        int                fd;
        int                code;
        int                tgt;
        int                hold;
        int                last_tgt;
        logic              done;
        logic [8*8-1:0]    kind;      // First token of a line
        logic [8*200-1:0]  line_buf;  // Rest of a comment line
        logic              e_hs;
        logic              e_vs;
        logic              e_de;
        logic [COLR_W-1:0] e_r;
        logic [COLR_W-1:0] e_g;
        logic [COLR_W-1:0] e_b;

        reset        = 1'b1;  // DUT held from time zero
        cyc          = 0;
        checks       = 0;
        mismatches   = 0;
        other_errors = 0;
        done         = 1'b0;
        last_tgt     = -1;

        fd = $fopen("tests/starfield_stim.txt", "r");
        if (fd == 0) begin
            $display("Could not open the stimulus file tests/starfield_stim.txt");
            other_errors++;
            done = 1'b1;  // Straight to the summary
        end

        // Power-on reset
        repeat (RESET_CYCLES) @(posedge clk_pix);
        #1 reset = 1'b0;
        cyc = 0;

        while (!done) begin
            code = $fscanf(fd, "%s", kind);
            if (code != 1) begin
                done = 1'b1;  // End of file
            end else if (kind == "#") begin
                code = $fgets(line_buf, fd);
            end else if (kind == "R") begin
                code = $fscanf(fd, "%d", hold);
                if (code != 1 || hold < 1) begin
                    $display("Reset line in the stimulus file has no valid length");
                    other_errors++;
                    done = 1'b1;
                end else begin
                    apply_reset(hold);
                    last_tgt = -1;  // Cycle numbers restart
                end
            end else if (kind == "S" || kind == "P") begin
                if (kind == "S") begin
                    code = $fscanf(fd, "%d %b %b %b", tgt, e_hs, e_vs, e_de);
                    code = (code == 4) ? 7 : 0;
                end else begin
                    code = $fscanf(fd, "%d %b %b %b %h %h %h",
                                   tgt, e_hs, e_vs, e_de, e_r, e_g, e_b);
                end
                if (code != 7) begin
                    $display("Check line in the stimulus file is malformed");
                    other_errors++;
                    done = 1'b1;
                end else if (tgt <= last_tgt) begin
                    $display("Check for cycle %0d comes after cycle %0d in the stimulus file",
                             tgt, last_tgt);
                    other_errors++;
                end else begin
                    advance_to(tgt);
                    last_tgt = tgt;
                    compare_flag("hsync_out", hsync_out, e_hs);
                    compare_flag("vsync_out", vsync_out, e_vs);
                    compare_flag("de_out", de_out, e_de);
                    if (kind == "P") begin
                        verify_colour("red", red, e_r);
                        verify_colour("green", green, e_g);
                        verify_colour("blue", blue, e_b);
                    end else begin
                        // Star value unknown here, channels still equal
                        verify_colour("green", green, red);
                        verify_colour("blue", blue, red);
                    end
                end
            end else begin
                $display("Unknown line type %0s in the stimulus file", kind);
                other_errors++;
                done = 1'b1;
            end
        end
        if (fd != 0)
            $fclose(fd);

        if (checks == 0) begin
            $display("No checks were read from the stimulus file");
            other_errors++;
        end
        $display("Checks: %0d, mismatches: %0d, other errors: %0d",
                 checks, mismatches, other_errors);
        if (mismatches == 0 && other_errors == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule
